// ==== source/ls_pkg.sv ====
/*
 * Load/store unit shared definitions
 * Address map, exception codes, access sizes and the packed
 * structs passed between the unit's blocks and the AXI4-Lite bus
 */
package ls_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address map
    localparam logic [31:0] LOCAL_BASE = 32'h0000_0000;
    localparam int LOCAL_WORDS = 256;
    localparam int LOCAL_AW = $clog2(LOCAL_WORDS);
    localparam logic [31:0] PERIPH_BASE = 32'h8000_0000;
    localparam logic [31:0] PERIPH_LIMIT = 32'h8000_FFFF;

    // Queue depths
    localparam int REQ_QUEUE_DEPTH = 4;
    localparam int ATTR_QUEUE_DEPTH = 2;

    localparam int ID_W = 4;
    typedef logic [ID_W-1:0] ls_id_t;

    // Exception causes
    localparam logic [3:0] EXC_LOAD_MISALIGNED = 4'd4;
    localparam logic [3:0] EXC_LOAD_FAULT = 4'd5;
    localparam logic [3:0] EXC_STORE_MISALIGNED = 4'd6;
    localparam logic [3:0] EXC_STORE_FAULT = 4'd7;

    // Same encoding as the low two bits of fn3
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } ls_size_t;

    typedef enum logic {
        SUB_LOCAL = 1'b0,
        SUB_PERIPH = 1'b1
    } ls_subunit_t;

    //////////////////////////////////////////////////////////////////////
    // Request and result records
    typedef struct packed {
        logic is_store;
        logic [2:0] fn3;
        logic [31:0] rs1;
        logic [11:0] offset;
        logic [31:0] store_data;
        ls_id_t id;
    } ls_issue_t;

    typedef struct packed {
        logic [29:0] word_addr;
        logic is_store;
        logic [3:0] be;
        logic [31:0] wdata;
        ls_size_t size;
        logic is_signed;
        logic [1:0] byte_off;
        ls_subunit_t subunit;
        ls_id_t id;
    } ls_request_t;

    typedef struct packed {
        ls_size_t size;
        logic is_signed;
        logic [1:0] byte_off;
        ls_subunit_t subunit;
        ls_id_t id;
    } ls_load_attr_t;

    typedef struct packed {
        ls_id_t id;
        logic [31:0] data;
    } ls_wb_t;

    typedef struct packed {
        ls_id_t id;
        logic [3:0] code;
        logic [31:0] tval;
    } ls_exc_t;

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite channels
    typedef struct packed {
        logic awvalid;
        logic [31:0] awaddr;
        logic wvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic bready;
        logic arvalid;
        logic [31:0] araddr;
        logic rready;
    } axi_lite_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [31:0] rdata;
        logic [1:0] rresp;
    } axi_lite_rsp_t;

endpackage

// ==== source/ls_fifo.sv ====
/*
 * Synchronous FIFO
 * Circular buffer of any payload type, head visible without a pop
 */
`timescale 1ns/1ps

module ls_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic push,
    input payload_t data_in,
    input logic pop,
    output payload_t data_out,
    output logic valid,
    output logic full
);

    payload_t entries [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH):0] count;
    logic do_pop;

    assign do_pop = pop & valid;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push & ~do_pop)
                count <= count + 1'b1;
            else if (do_pop & ~push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    assign data_out = entries[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == ($clog2(DEPTH) + 1)'(DEPTH));

endmodule

// ==== source/ls_issue_decode.sv ====
/*
 * Issue decode
 * Forms the effective address, checks alignment and region, and
 * builds byte enables and lane-placed store data for the queue
 */
`timescale 1ns/1ps

module ls_issue_decode
    import ls_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input ls_issue_t issue,
    input logic queue_full,
    output logic issue_ready,
    output logic push,
    output ls_request_t request,
    output logic exc_valid,
    output ls_exc_t exc
);

    logic out_of_reset;
    logic accept;
    logic [31:0] eff_addr;
    ls_size_t size;
    logic misaligned;
    logic in_local;
    logic in_periph;
    logic [3:0] be;

    always_ff @(posedge clk) begin
        if (rst)
            out_of_reset <= 1'b0;
        else
            out_of_reset <= 1'b1;
    end

    assign issue_ready = out_of_reset & ~queue_full;
    assign accept = issue_valid & issue_ready;

    //////////////////////////////////////////////////////////////////////
    // Address generation and checks
    assign eff_addr = issue.rs1 + {{20{issue.offset[11]}}, issue.offset};

    always_comb begin
        case (issue.fn3[1:0])
            2'b00: size = SIZE_BYTE;
            2'b01: size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
    end

    always_comb begin
        case (size)
            SIZE_HALF: misaligned = eff_addr[0];
            SIZE_WORD: misaligned = |eff_addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Offsets from each base keep the compares free of wraparound
    assign in_local = (eff_addr - LOCAL_BASE) < 32'(LOCAL_WORDS * 4);
    assign in_periph = (eff_addr - PERIPH_BASE) <= (PERIPH_LIMIT - PERIPH_BASE);

    //////////////////////////////////////////////////////////////////////
    // Byte lanes
    always_comb begin
        case (size)
            SIZE_BYTE: be = 4'b0001 << eff_addr[1:0];
            SIZE_HALF: be = 4'b0011 << eff_addr[1:0];
            default: be = 4'b1111;
        endcase
    end

    assign push = accept & ~misaligned & (in_local | in_periph);

    assign request = '{
        word_addr: eff_addr[31:2],
        is_store: issue.is_store,
        be: be,
        wdata: issue.store_data << {eff_addr[1:0], 3'b000},
        size: size,
        is_signed: ~issue.fn3[2],
        byte_off: eff_addr[1:0],
        subunit: in_periph ? SUB_PERIPH : SUB_LOCAL,
        id: issue.id
    };

    //////////////////////////////////////////////////////////////////////
    // Exception report, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst)
            exc_valid <= 1'b0;
        else
            exc_valid <= accept & (misaligned | ~(in_local | in_periph));
    end

    // Misalignment outranks a missing region
    always_ff @(posedge clk) begin
        if (accept) begin
            exc.id <= issue.id;
            exc.tval <= eff_addr;
            if (issue.is_store)
                exc.code <= misaligned ? EXC_STORE_MISALIGNED : EXC_STORE_FAULT;
            else
                exc.code <= misaligned ? EXC_LOAD_MISALIGNED : EXC_LOAD_FAULT;
        end
    end

endmodule

// ==== source/ls_dispatch.sv ====
/*
 * Request dispatch
 * Issues queued requests in order to the local memory or the
 * peripheral bus, and steers returning load data to writeback
 */
`timescale 1ns/1ps

module ls_dispatch
    import ls_pkg::*;
(
    input logic clk,
    input logic rst,
    input ls_request_t head,
    input logic head_valid,
    output logic pop,
    output logic attr_push,
    output ls_load_attr_t attr_in,
    input ls_load_attr_t attr_head,
    input logic attr_valid,
    output logic attr_pop,
    input logic local_ready,
    input logic local_rd_valid,
    input logic [31:0] local_rd_data,
    input logic periph_ready,
    input logic periph_rd_valid,
    input logic [31:0] periph_rd_data,
    output logic local_req,
    output logic periph_req,
    output logic rd_valid,
    output logic [31:0] rd_data,
    output logic busy
);

    ls_subunit_t last_unit;
    logic unit_switch;
    logic switch_in_progress;
    logic switch_hold;
    logic head_is_load;
    logic target_ready;

    //////////////////////////////////////////////////////////////////////
    // Sub-unit switch hold
    // A load to the other sub-unit waits for the loads in flight
    // to return, so two results never land in the same cycle
    assign head_is_load = head_valid & ~head.is_store;
    assign unit_switch = head_is_load & (head.subunit != last_unit) & attr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= SUB_LOCAL;
            switch_in_progress <= 1'b0;
        end else begin
            if (attr_push)
                last_unit <= head.subunit;
            switch_in_progress <= (switch_in_progress | unit_switch) & attr_valid;
        end
    end

    assign switch_hold = unit_switch | switch_in_progress;

    //////////////////////////////////////////////////////////////////////
    // Issue
    assign target_ready = (head.subunit == SUB_PERIPH) ? periph_ready : local_ready;
    assign pop = head_valid & target_ready & ~switch_hold;

    assign local_req = pop & (head.subunit == SUB_LOCAL);
    assign periph_req = pop & (head.subunit == SUB_PERIPH);

    assign attr_push = pop & ~head.is_store;
    assign attr_in = '{
        size: head.size,
        is_signed: head.is_signed,
        byte_off: head.byte_off,
        subunit: head.subunit,
        id: head.id
    };

    //////////////////////////////////////////////////////////////////////
    // Load return
    always_comb begin
        if (attr_head.subunit == SUB_PERIPH) begin
            rd_valid = periph_rd_valid;
            rd_data = periph_rd_data;
        end else begin
            rd_valid = local_rd_valid;
            rd_data = local_rd_data;
        end
    end

    assign attr_pop = rd_valid;
    assign busy = head_valid | attr_valid | switch_in_progress;

endmodule

// ==== source/ls_local_mem.sv ====
/*
 * Local data memory
 * Word array with byte-enabled writes and a one-cycle read
 */
`timescale 1ns/1ps

module ls_local_mem
    import ls_pkg::*;
(
    input logic clk,
    input logic req,
    input ls_request_t request,
    output logic rd_valid,
    output logic [31:0] rd_data
);

    logic [31:0] mem [LOCAL_WORDS];
    logic [LOCAL_AW-1:0] index;

    assign index = LOCAL_AW'(request.word_addr - LOCAL_BASE[31:2]);

    always_ff @(posedge clk) begin
        if (req & request.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (request.be[i])
                    mem[index][i*8 +: 8] <= request.wdata[i*8 +: 8];
            end
        end
    end

    // Whole word comes back, lane selection happens at writeback
    always_ff @(posedge clk) begin
        rd_valid <= req & ~request.is_store;
        if (req & ~request.is_store)
            rd_data <= mem[index];
    end

endmodule

// ==== source/ls_axi_lite_master.sv ====
/*
 * Peripheral bus master
 * Runs one AXI4-Lite read or write at a time for the load/store unit
 */
`timescale 1ns/1ps

module ls_axi_lite_master
    import ls_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic req,
    input ls_request_t request,
    output logic ready,
    output logic rd_valid,
    output logic [31:0] rd_data,
    output logic busy,
    output axi_lite_req_t m_axi_req,
    input axi_lite_rsp_t m_axi_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT_B,
        ST_WAIT_R
    } state_t;

    state_t state;
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    logic is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;

    assign aw_hs = m_axi_req.awvalid & m_axi_rsp.awready;
    assign w_hs = m_axi_req.wvalid & m_axi_rsp.wready;

    //////////////////////////////////////////////////////////////////////
    // Transaction FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done <= 1'b0;
                    if (req)
                        state <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (is_write) begin
                        // AW and W may be taken in either order
                        if (aw_hs)
                            aw_done <= 1'b1;
                        if (w_hs)
                            w_done <= 1'b1;
                        if ((aw_done | aw_hs) & (w_done | w_hs))
                            state <= ST_WAIT_B;
                    end else if (m_axi_rsp.arready) begin
                        state <= ST_WAIT_R;
                    end
                end
                ST_WAIT_B: begin
                    if (m_axi_rsp.bvalid)
                        state <= ST_IDLE;
                end
                default: begin
                    if (m_axi_rsp.rvalid)
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request held for the whole transaction
    always_ff @(posedge clk) begin
        if (req & (state == ST_IDLE)) begin
            is_write <= request.is_store;
            addr <= {request.word_addr, 2'b00};
            wdata <= request.wdata;
            wstrb <= request.be;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus outputs
    always_comb begin
        m_axi_req.awvalid = (state == ST_ADDR) & is_write & ~aw_done;
        m_axi_req.awaddr = addr;
        m_axi_req.wvalid = (state == ST_ADDR) & is_write & ~w_done;
        m_axi_req.wdata = wdata;
        m_axi_req.wstrb = wstrb;
        m_axi_req.bready = (state == ST_WAIT_B);
        m_axi_req.arvalid = (state == ST_ADDR) & ~is_write;
        m_axi_req.araddr = addr;
        m_axi_req.rready = (state == ST_WAIT_R);
    end

    assign ready = (state == ST_IDLE);
    assign busy = (state != ST_IDLE);
    assign rd_valid = (state == ST_WAIT_R) & m_axi_rsp.rvalid;
    assign rd_data = m_axi_rsp.rdata;

endmodule

// ==== source/ls_load_align.sv ====
/*
 * Load alignment
 * Picks the byte or halfword lane and extends it to 32 bits
 */
`timescale 1ns/1ps

module ls_load_align
    import ls_pkg::*;
(
    input ls_load_attr_t attr,
    input logic rd_valid,
    input logic [31:0] rd_data,
    output logic wb_valid,
    output ls_wb_t wb
);

    logic [7:0] byte_lane;
    logic [15:0] half_lane;

    // Halfwords are aligned, so the upper offset bit picks the lane
    assign byte_lane = rd_data[attr.byte_off*8 +: 8];
    assign half_lane = attr.byte_off[1] ? rd_data[31:16] : rd_data[15:0];

    always_comb begin
        case (attr.size)
            SIZE_BYTE: wb.data = {{24{attr.is_signed & byte_lane[7]}}, byte_lane};
            SIZE_HALF: wb.data = {{16{attr.is_signed & half_lane[15]}}, half_lane};
            default: wb.data = rd_data;
        endcase
    end

    assign wb.id = attr.id;
    assign wb_valid = rd_valid;

endmodule

// ==== source/load_store_unit.sv ====
/*
 * Load/store unit top
 * Issue decode, request and load-attribute queues, dispatch to local
 * memory or the AXI4-Lite peripheral bus, and load writeback
 */
`timescale 1ns/1ps

module load_store_unit
    import ls_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input ls_issue_t issue,
    output logic issue_ready,
    output logic wb_valid,
    output ls_wb_t wb,
    output logic exc_valid,
    output ls_exc_t exc,
    output logic idle,
    output axi_lite_req_t m_axi_req,
    input axi_lite_rsp_t m_axi_rsp
);

    logic push;
    logic queue_full;
    ls_request_t request;
    ls_request_t head;
    logic head_valid;
    logic pop;

    logic attr_push;
    logic attr_pop;
    logic attr_valid;
    ls_load_attr_t attr_in;
    ls_load_attr_t attr_head;

    logic local_req;
    logic local_rd_valid;
    logic [31:0] local_rd_data;
    logic periph_req;
    logic periph_ready;
    logic periph_rd_valid;
    logic [31:0] periph_rd_data;
    logic periph_busy;

    logic rd_valid;
    logic [31:0] rd_data;
    logic dispatch_busy;

    ls_issue_decode decode (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue (issue),
        .queue_full (queue_full),
        .issue_ready (issue_ready),
        .push (push),
        .request (request),
        .exc_valid (exc_valid),
        .exc (exc)
    );

    ls_fifo #(.payload_t(ls_request_t), .DEPTH(REQ_QUEUE_DEPTH)) req_queue (
        .clk (clk),
        .rst (rst),
        .push (push),
        .data_in (request),
        .pop (pop),
        .data_out (head),
        .valid (head_valid),
        .full (queue_full)
    );

    // Holds at most two loads, which the switch hold guarantees
    ls_fifo #(.payload_t(ls_load_attr_t), .DEPTH(ATTR_QUEUE_DEPTH)) attr_queue (
        .clk (clk),
        .rst (rst),
        .push (attr_push),
        .data_in (attr_in),
        .pop (attr_pop),
        .data_out (attr_head),
        .valid (attr_valid),
        .full ()
    );

    ls_dispatch dispatch (
        .clk (clk),
        .rst (rst),
        .head (head),
        .head_valid (head_valid),
        .pop (pop),
        .attr_push (attr_push),
        .attr_in (attr_in),
        .attr_head (attr_head),
        .attr_valid (attr_valid),
        .attr_pop (attr_pop),
        .local_ready (1'b1),
        .local_rd_valid (local_rd_valid),
        .local_rd_data (local_rd_data),
        .periph_ready (periph_ready),
        .periph_rd_valid (periph_rd_valid),
        .periph_rd_data (periph_rd_data),
        .local_req (local_req),
        .periph_req (periph_req),
        .rd_valid (rd_valid),
        .rd_data (rd_data),
        .busy (dispatch_busy)
    );

    ls_local_mem local_mem (
        .clk (clk),
        .req (local_req),
        .request (head),
        .rd_valid (local_rd_valid),
        .rd_data (local_rd_data)
    );

    ls_axi_lite_master axi_master (
        .clk (clk),
        .rst (rst),
        .req (periph_req),
        .request (head),
        .ready (periph_ready),
        .rd_valid (periph_rd_valid),
        .rd_data (periph_rd_data),
        .busy (periph_busy),
        .m_axi_req (m_axi_req),
        .m_axi_rsp (m_axi_rsp)
    );

    ls_load_align load_align (
        .attr (attr_head),
        .rd_valid (rd_valid),
        .rd_data (rd_data),
        .wb_valid (wb_valid),
        .wb (wb)
    );

    assign idle = ~dispatch_busy & ~periph_busy;

endmodule

// ==== verif/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 4 ns clock, reset held high for the first 16 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== verif/ls_unit_chk.sv ====
/*
 * Dispatch assertions
 * Load return, switch hold and sub-unit select rules
 */
`timescale 1ns/1ps

module ls_unit_chk
    import ls_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic rd_valid,
    input logic attr_valid,
    input logic attr_push,
    input ls_load_attr_t attr_in,
    input ls_load_attr_t attr_head,
    input logic local_rd_valid,
    input logic periph_rd_valid
);

    // Returning data always has a load attribute waiting for it
    assert property (@(posedge clk) disable iff (rst) rd_valid |-> attr_valid)
        else $error("load data returned with no load attribute queued");

    // Loads in flight all target one sub-unit
    assert property (@(posedge clk) disable iff (rst)
        (attr_push && attr_valid) |-> (attr_in.subunit == attr_head.subunit))
        else $error("load issued to a second sub-unit while loads are in flight");

    // Every returning load is steered to writeback
    assert property (@(posedge clk) disable iff (rst)
        (local_rd_valid || periph_rd_valid) |-> rd_valid)
        else $error("returning load data not selected for writeback");

endmodule

bind ls_dispatch ls_unit_chk chk (.*);

// ==== verif/tb_load_store_unit.sv ====
/*
 * Load/store unit testbench
 * AXI4-Lite slave model, shadow memories, reference model and checks
 */
`timescale 1ns/1ps

module tb_load_store_unit
    import ls_pkg::*;
();

    localparam logic [2:0] FN_B = 3'b000;
    localparam logic [2:0] FN_H = 3'b001;
    localparam logic [2:0] FN_W = 3'b010;
    localparam logic [2:0] FN_BU = 3'b100;
    localparam logic [2:0] FN_HU = 3'b101;
    localparam int PERIPH_WORDS = 16384;

    typedef struct packed {
        logic is_exc;
        logic has_wb;
        ls_wb_t wb;
        ls_exc_t exc;
    } expect_t;

    logic clk;
    logic rst;
    logic issue_valid;
    ls_issue_t issue;
    logic issue_ready;
    logic wb_valid;
    ls_wb_t wb;
    logic exc_valid;
    ls_exc_t exc;
    logic idle;
    axi_lite_req_t m_axi_req;
    axi_lite_rsp_t m_axi_rsp;

    logic [31:0] ref_local [LOCAL_WORDS];
    logic [31:0] ref_periph [PERIPH_WORDS];
    logic [31:0] periph_mem [PERIPH_WORDS];
    ls_wb_t exp_wb [$];
    ls_exc_t exp_exc [$];
    int exc_cycles [$];
    logic [15:0] lfsr = 16'd18025;
    int cycle = 0;
    int issued = 0;
    logic [ID_W-1:0] next_id = '0;
    logic watch_full = 1'b0;
    logic saw_full = 1'b0;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    load_store_unit uut (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue (issue),
        .issue_ready (issue_ready),
        .wb_valid (wb_valid),
        .wb (wb),
        .exc_valid (exc_valid),
        .exc (exc),
        .idle (idle),
        .m_axi_req (m_axi_req),
        .m_axi_rsp (m_axi_rsp)
    );

    // Galois LFSR, one step per bit
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++)
            w[i] = take_bit();
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    function automatic expect_t ref_access(ls_issue_t r);
        expect_t e;
        logic [31:0] ea;
        logic [31:0] word;
        logic [31:0] shifted;
        int nbytes;
        logic mis;
        logic loc;
        logic per;
        ea = r.rs1 + {{20{r.offset[11]}}, r.offset};
        nbytes = (r.fn3[1:0] == 2'b00) ? 1 : (r.fn3[1:0] == 2'b01) ? 2 : 4;
        mis = (nbytes == 2 && ea[0]) || (nbytes == 4 && ea[1:0] != 2'b00);
        loc = ea < 32'd1024;
        per = ea >= 32'h8000_0000 && ea <= 32'h8000_FFFF;
        e = '0;
        if (mis || !(loc || per)) begin
            e.is_exc = 1'b1;
            e.exc.id = r.id;
            e.exc.tval = ea;
            if (r.is_store)
                e.exc.code = mis ? EXC_STORE_MISALIGNED : EXC_STORE_FAULT;
            else
                e.exc.code = mis ? EXC_LOAD_MISALIGNED : EXC_LOAD_FAULT;
            return e;
        end
        word = loc ? ref_local[ea[9:2]] : ref_periph[ea[15:2]];
        if (r.is_store) begin
            for (int i = 0; i < nbytes; i++)
                word[(int'(ea[1:0]) + i) * 8 +: 8] = r.store_data[i * 8 +: 8];
            if (loc)
                ref_local[ea[9:2]] = word;
            else
                ref_periph[ea[15:2]] = word;
            return e;
        end
        shifted = word >> (int'(ea[1:0]) * 8);
        e.has_wb = 1'b1;
        e.wb.id = r.id;
        if (nbytes == 1)
            e.wb.data = {{24{~r.fn3[2] & shifted[7]}}, shifted[7:0]};
        else if (nbytes == 2)
            e.wb.data = {{16{~r.fn3[2] & shifted[15]}}, shifted[15:0]};
        else
            e.wb.data = shifted;
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    task automatic fail_plain(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping after error");
    endtask

    task automatic check_wb(ls_wb_t got, ls_wb_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: wb id %0d data %h, expected id %0d data %h",
                $time, got.id, got.data, want.id, want.data);
            $display("Test failures found");
            $fatal(1, "writeback mismatch");
        end
    endtask

    task automatic check_exc(ls_exc_t got, ls_exc_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: exc id %0d code %0d tval %h, expected %0d %0d %h",
                $time, got.id, got.code, got.tval, want.id, want.code, want.tval);
            $display("Test failures found");
            $fatal(1, "exception mismatch");
        end
    endtask

    // Outputs sampled at the falling edge, where they are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid) begin
                if (exp_wb.size() == 0)
                    fail_plain("writeback with no load outstanding");
                check_wb(wb, exp_wb.pop_front());
            end
            if (exc_valid) begin
                if (exp_exc.size() == 0)
                    fail_plain("exception with none expected");
                if (exc_cycles.pop_front() != cycle)
                    fail_plain("exception not one cycle after acceptance");
                check_exc(exc, exp_exc.pop_front());
            end else if (exc_cycles.size() != 0 && exc_cycles[0] <= cycle) begin
                fail_plain("expected exception never reported");
            end
            if (watch_full && !issue_ready)
                saw_full <= 1'b1;
        end else if (issue_ready === 1'b1 || wb_valid === 1'b1 || exc_valid === 1'b1
                     || m_axi_req.awvalid === 1'b1 || m_axi_req.wvalid === 1'b1
                     || m_axi_req.arvalid === 1'b1) begin
            fail_plain("unit output active during reset");
        end
    end

    // Watchdog scaled to the number of issued requests
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 20 * issued + 200) begin
            $display("Test failures found");
            $fatal(1, "Timeout: the unit stopped making progress");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite slave model
    initial begin
        for (int i = 0; i < PERIPH_WORDS; i++) begin
            periph_mem[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0193);
            ref_periph[i] = periph_mem[i];
        end
    end

    always begin : axi_slave
        axi_lite_rsp_t nxt;
        logic got_aw;
        logic got_w;
        logic got_ar;
        logic [31:0] waddr;
        logic [31:0] raddr;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        m_axi_rsp = '0;
        got_aw = 1'b0;
        got_w = 1'b0;
        got_ar = 1'b0;
        forever begin
            @(negedge clk);
            nxt = m_axi_rsp;
            // Write path
            if (m_axi_rsp.bvalid && m_axi_req.bready) begin
                nxt.bvalid = 1'b0;
                got_aw = 1'b0;
                got_w = 1'b0;
            end else if (got_aw && got_w && !m_axi_rsp.bvalid && take_bit()) begin
                for (int i = 0; i < 4; i++)
                    if (wstrb[i])
                        periph_mem[waddr[15:2]][i * 8 +: 8] = wdata[i * 8 +: 8];
                nxt.bvalid = 1'b1;
            end
            if (m_axi_rsp.awready && m_axi_req.awvalid) begin
                got_aw = 1'b1;
                waddr = m_axi_req.awaddr;
                nxt.awready = 1'b0;
            end else begin
                nxt.awready = m_axi_req.awvalid && !got_aw && take_bit();
            end
            if (m_axi_rsp.wready && m_axi_req.wvalid) begin
                got_w = 1'b1;
                wdata = m_axi_req.wdata;
                wstrb = m_axi_req.wstrb;
                nxt.wready = 1'b0;
            end else begin
                nxt.wready = m_axi_req.wvalid && !got_w && take_bit();
            end
            // Read path
            if (m_axi_rsp.rvalid && m_axi_req.rready) begin
                nxt.rvalid = 1'b0;
                got_ar = 1'b0;
            end else if (got_ar && !m_axi_rsp.rvalid && take_bit()) begin
                nxt.rvalid = 1'b1;
                nxt.rdata = periph_mem[raddr[15:2]];
            end
            if (m_axi_rsp.arready && m_axi_req.arvalid) begin
                got_ar = 1'b1;
                raddr = m_axi_req.araddr;
                nxt.arready = 1'b0;
            end else begin
                nxt.arready = m_axi_req.arvalid && !got_ar && take_bit();
            end
            @(posedge clk);
            #1 m_axi_rsp = nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    // Called 1 ns after a rising edge, returns 1 ns after acceptance
    task automatic issue_req(logic st, logic [2:0] fn3, logic [31:0] rs1,
                             logic [11:0] off, logic [31:0] data);
        expect_t e;
        issue_valid = 1'b1;
        issue = '{is_store: st, fn3: fn3, rs1: rs1, offset: off,
                  store_data: data, id: next_id};
        next_id = next_id + 1'b1;
        do
            @(negedge clk);
        while (!issue_ready);
        e = ref_access(issue);
        if (e.is_exc) begin
            exp_exc.push_back(e.exc);
            exc_cycles.push_back(cycle + 1);
        end
        if (e.has_wb)
            exp_wb.push_back(e.wb);
        issued++;
        @(posedge clk);
        #1;
    endtask

    // Stores of every size, then every kind of load, over eight words
    task automatic access_mix(logic [31:0] base);
        for (int i = 0; i < 8; i++)
            issue_req(1'b1, FN_W, base, 12'(i * 4), rand_word());
        for (int i = 0; i < 8; i++) begin
            issue_req(1'b1, FN_H, base, 12'(i * 4 + 2), rand_word());
            issue_req(1'b1, FN_B, base, 12'(i * 4 + 1), rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            issue_req(1'b0, FN_W, base, 12'(i * 4), '0);
            issue_req(1'b0, FN_H, base, 12'(i * 4 + 2), '0);
            issue_req(1'b0, FN_HU, base, 12'(i * 4), '0);
            issue_req(1'b0, FN_B, base, 12'(i * 4 + 3), '0);
            issue_req(1'b0, FN_BU, base, 12'(i * 4 + 1), '0);
        end
    endtask

    initial begin
        issue_valid = 1'b0;
        issue = '0;
        wait (rst == 1'b0);
        @(posedge clk);
        #1;

        // Local memory then peripheral region
        access_mix(32'h0000_0040);
        access_mix(PERIPH_BASE + 32'h100);

        // Misaligned accesses, then the words are read back untouched
        issue_req(1'b0, FN_H, 32'h0000_0041, 12'd0, '0);
        issue_req(1'b0, FN_W, 32'h0000_0040, 12'd2, '0);
        issue_req(1'b1, FN_H, 32'h0000_0043, 12'd0, 32'hDEAD_BEEF);
        issue_req(1'b1, FN_W, PERIPH_BASE + 32'h100, 12'd2, 32'hCAFE_F00D);
        issue_req(1'b0, FN_HU, PERIPH_BASE + 32'h105, 12'd0, '0);
        issue_req(1'b0, FN_W, 32'h0000_0040, 12'd0, '0);
        issue_req(1'b0, FN_W, PERIPH_BASE + 32'h100, 12'd0, '0);

        // No region
        issue_req(1'b0, FN_W, 32'h4000_0000, 12'd0, '0);
        issue_req(1'b1, FN_W, 32'h0000_0400, 12'd0, 32'h1234_5678);
        issue_req(1'b0, FN_B, 32'h8001_0000, 12'd0, '0);
        issue_req(1'b1, FN_B, 32'h0000_0000, 12'hFFF, 32'h0000_00AA);

        // Alternating sub-units, back to back
        watch_full = 1'b1;
        for (int i = 0; i < 12; i++) begin
            issue_req(1'b0, FN_W, 32'h0000_0040, 12'((i % 8) * 4), '0);
            issue_req(1'b0, FN_W, PERIPH_BASE + 32'h100, 12'(i * 4), '0);
        end
        issue_valid = 1'b0;

        while (!(idle && exp_wb.size() == 0 && exp_exc.size() == 0))
            @(negedge clk);
        repeat (4) @(negedge clk);

        if (!saw_full || !idle || exp_wb.size() != 0 || exp_exc.size() != 0) begin
            $display("ERROR: request queue never filled or results left over at the end");
            $display("Test failures found");
            $fatal(1, "end of run check");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== all.f ====
source/ls_pkg.sv
source/ls_fifo.sv
source/ls_issue_decode.sv
source/ls_dispatch.sv
source/ls_local_mem.sv
source/ls_axi_lite_master.sv
source/ls_load_align.sv
source/load_store_unit.sv
verif/tb_clock_gen.sv
verif/ls_unit_chk.sv
verif/tb_load_store_unit.sv

// ==== Makefile ====
TOP := tb_load_store_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall source/ls_pkg.sv source/ls_fifo.sv \
		source/ls_issue_decode.sv source/ls_dispatch.sv source/ls_local_mem.sv \
		source/ls_axi_lite_master.sv source/ls_load_align.sv \
		source/load_store_unit.sv --top-module load_store_unit

clean:
	rm -rf obj_dir
